//--- tb.f
hdl/camera_pkg.sv
hdl/pixel_stream_if.sv
hdl/raw10_unpacker.sv
hdl/pixel_group_fifo.sv
hdl/frame_packer.sv
hdl/frame_ram.sv
hdl/camera_top.sv
bench/camera_checker.sv
bench/camera_tb.sv

//--- Bender.yml
package:
  name: camera_raw10_crop

sources:
  - files:
      - hdl/camera_pkg.sv
      - hdl/pixel_stream_if.sv
      - hdl/raw10_unpacker.sv
      - hdl/pixel_group_fifo.sv
      - hdl/frame_packer.sv
      - hdl/frame_ram.sv
      - hdl/camera_top.sv
  - target: test
    files:
      - bench/camera_checker.sv
      - bench/camera_tb.sv

//--- bench/camera_tb.sv
/*
 * Testbench for camera_top. Sends random RAW10 frames with random idle gaps,
 * waits for frame_done_o and reads the crop back. Inputs change on falling edges.
 */

`timescale 1ns/1ps

module camera_tb;
    import camera_pkg::*;

    localparam int LINES      = CROP_Y0 + CROP_H + 1;
    localparam int LINE_BYTES = LINE_PIXELS * 5 / 4;
    localparam int CROP_WORDS = CROP_H * CROP_W / 4;
    localparam int FRAMES     = 3;
    localparam int TIMEOUT    = 2000;   // cycles per wait

    logic                  byte_clk_hs;
    logic                  reset_n_byte;
    logic                  sp_en_i;
    logic                  frame_start_i;
    logic                  payload_en_i;
    logic [7:0]            payload_i;
    logic                  ram_read_en_i;
    logic [RAM_ADDR_W-1:0] ram_read_addr_i;
    logic [31:0]           ram_read_data_o;
    logic                  frame_done_o;
    int                    checker_errors;
    int                    done_count;
    int                    bench_errors;

    camera_top u_camera_top (
        .byte_clk_hs     (byte_clk_hs),
        .reset_n_byte    (reset_n_byte),
        .sp_en_i         (sp_en_i),
        .frame_start_i   (frame_start_i),
        .payload_en_i    (payload_en_i),
        .payload_i       (payload_i),
        .ram_read_en_i   (ram_read_en_i),
        .ram_read_addr_i (ram_read_addr_i),
        .ram_read_data_o (ram_read_data_o),
        .frame_done_o    (frame_done_o)
    );

    camera_checker u_camera_checker (
        .byte_clk_hs     (byte_clk_hs),
        .reset_n_byte    (reset_n_byte),
        .sp_en_i         (sp_en_i),
        .frame_start_i   (frame_start_i),
        .payload_en_i    (payload_en_i),
        .payload_i       (payload_i),
        .ram_read_en_i   (ram_read_en_i),
        .ram_read_addr_i (ram_read_addr_i),
        .ram_read_data_i (ram_read_data_o),
        .frame_done_i    (frame_done_o),
        .error_count_o   (checker_errors),
        .done_count_o    (done_count)
    );

    initial byte_clk_hs = 1'b0;
    always #2 byte_clk_hs = ~byte_clk_hs;

    // one packet is a start strobe then random bytes with 0 or 1 idle cycles each
    task automatic send_line(input bit first);
        sp_en_i       = 1'b1;
        frame_start_i = first;
        @(negedge byte_clk_hs);
        sp_en_i       = 1'b0;
        frame_start_i = 1'b0;
        for (int b = 0; b < LINE_BYTES; b++) begin
            payload_en_i = 1'b1;
            payload_i    = 8'($urandom);
            @(negedge byte_clk_hs);
            payload_en_i = 1'b0;
            if ($urandom % 2)
                @(negedge byte_clk_hs);
        end
        repeat (2) @(negedge byte_clk_hs);
    endtask

    task automatic wait_frame_done(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target && cycles < TIMEOUT) begin
            @(negedge byte_clk_hs);
            cycles++;
        end
        if (done_count < target) begin
            $display("timeout: no frame_done_o for frame %0d within %0d cycles",
                     target, TIMEOUT);
            bench_errors++;
        end
    endtask

    task automatic read_crop();
        for (int a = 0; a < CROP_WORDS; a++) begin
            ram_read_en_i   = 1'b1;
            ram_read_addr_i = RAM_ADDR_W'(a);
            @(negedge byte_clk_hs);
        end
        ram_read_en_i = 1'b0;
        repeat (2) @(negedge byte_clk_hs);
    endtask

    initial begin
        reset_n_byte    = 1'b0;
        sp_en_i         = 1'b0;
        frame_start_i   = 1'b0;
        payload_en_i    = 1'b0;
        payload_i       = '0;
        ram_read_en_i   = 1'b0;
        ram_read_addr_i = '0;
        bench_errors    = 0;
        void'($urandom(14));
        repeat (2) @(negedge byte_clk_hs);
        reset_n_byte = 1'b1;
        repeat (5) @(negedge byte_clk_hs);   // read data must stay 0 here

        for (int f = 1; f <= FRAMES; f++) begin
            for (int l = 0; l < LINES; l++)
                send_line(l == 0);
            wait_frame_done(f);
            repeat (20) @(negedge byte_clk_hs);
            if (done_count != f) begin
                $display("frame_done_o pulsed %0d times by frame %0d", done_count, f);
                bench_errors++;
            end
            read_crop();
        end

        $display("checker errors %0d, bench errors %0d", checker_errors, bench_errors);
        if (checker_errors == 0 && bench_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- bench/camera_checker.sv
/*
 * Reference model and scoreboard for camera_top. Rebuilds RAW10 pixels from
 * the input bytes, keeps the expected RAM image of the current frame and
 * checks host reads and frame_done_o. Assumes reads happen between frames.
 */

`timescale 1ns/1ps

module camera_checker (
    input  logic                              byte_clk_hs,
    input  logic                              reset_n_byte,
    input  logic                              sp_en_i,
    input  logic                              frame_start_i,
    input  logic                              payload_en_i,
    input  logic [7:0]                        payload_i,
    input  logic                              ram_read_en_i,
    input  logic [camera_pkg::RAM_ADDR_W-1:0] ram_read_addr_i,
    input  logic [31:0]                       ram_read_data_i,
    input  logic                              frame_done_i,
    output int                                error_count_o,
    output int                                done_count_o
);
    import camera_pkg::*;

    localparam int WORDS_PER_LINE = CROP_W / 4;

    logic [31:0]           exp_mem [RAM_WORDS];
    logic [7:0]            grp [5];        // bytes of the current group
    logic [RAM_ADDR_W-1:0] read_addr_q;
    bit                    read_pend;
    bit                    read_seen;
    bit                    done_in_frame;
    int                    line_idx;
    int                    byte_idx;
    int                    crop_pixels;

    task automatic store_group(input int g);
        logic [PIXEL_W-1:0] raw;
        int                 col;
        int                 rel;
        int                 addr;
        for (int i = 0; i < 4; i++) begin
            raw = {grp[i], grp[4][2*i +: 2]};
            col = g * 4 + i;
            if (line_idx >= CROP_Y0 && line_idx < CROP_Y0 + CROP_H
                    && col >= CROP_X0 && col < CROP_X0 + CROP_W) begin
                rel  = col - CROP_X0;
                addr = (line_idx - CROP_Y0) * WORDS_PER_LINE + rel / 4;
                exp_mem[addr][8*(rel%4) +: 8] = raw[PIXEL_W-1 -: 8];   // pixel 0 in low byte
                crop_pixels++;
            end
        end
    endtask

    always @(posedge byte_clk_hs or negedge reset_n_byte) begin
        if (!reset_n_byte) begin
            read_pend     = 1'b0;
            read_seen     = 1'b0;
            done_in_frame = 1'b0;
            line_idx      = -1;             // no frame seen yet
            byte_idx      = 0;
            crop_pixels   = 0;
            error_count_o = 0;
            done_count_o  = 0;
        end else begin
            // data now on the port answers the request of the last cycle
            if (read_pend) begin
                if (ram_read_data_i !== exp_mem[read_addr_q]) begin
                    $display("FAIL ram_read_data_o at 0x%h: expected 0x%h, observed 0x%h",
                             read_addr_q, exp_mem[read_addr_q], ram_read_data_i);
                    error_count_o++;
                end
            end else if (!read_seen && ram_read_data_i !== 32'h0) begin
                $display("FAIL ram_read_data_o after reset: expected 0x%h, observed 0x%h",
                         32'h0, ram_read_data_i);
                error_count_o++;
            end
            read_pend   = ram_read_en_i;
            read_addr_q = ram_read_addr_i;
            read_seen   = read_seen || ram_read_en_i;

            if (frame_done_i) begin
                done_count_o++;
                if (done_in_frame) begin
                    $display("frame_done_o pulsed more than once in one frame");
                    error_count_o++;
                end else if (crop_pixels < CROP_W * CROP_H) begin
                    $display("frame_done_o came before the crop window was received");
                    error_count_o++;
                end
                done_in_frame = 1'b1;
            end

            if (sp_en_i) begin
                byte_idx = 0;
                if (frame_start_i) begin
                    line_idx      = 0;
                    crop_pixels   = 0;
                    done_in_frame = 1'b0;
                end else if (line_idx >= 0) begin
                    line_idx++;
                end
            end else if (payload_en_i) begin
                grp[byte_idx % 5] = payload_i;
                if (byte_idx % 5 == 4)
                    store_group(byte_idx / 5);
                byte_idx++;
            end
        end
    end

endmodule

//--- hdl/camera_top.sv
/*
 * RAW10 to cropped 8-bit frame buffer, single clock byte_clk_hs.
 * Inputs come from a CSI-2 packet decoder, reads come from the host.
 */

`timescale 1ns/1ps

module camera_top (
    input  logic                              byte_clk_hs,
    input  logic                              reset_n_byte,
    input  logic                              sp_en_i,
    input  logic                              frame_start_i,
    input  logic                              payload_en_i,
    input  logic [7:0]                        payload_i,
    input  logic                              ram_read_en_i,
    input  logic [camera_pkg::RAM_ADDR_W-1:0] ram_read_addr_i,
    output logic [31:0]                       ram_read_data_o,
    output logic                              frame_done_o
);
    import camera_pkg::*;

    logic                  group_valid;
    pixel_group_t          group;
    logic                  wr_en;
    logic [RAM_ADDR_W-1:0] wr_addr;
    logic [31:0]           wr_data;

    pixel_stream_if u_pix_if ();

    raw10_unpacker u_raw10_unpacker (
        .byte_clk_hs   (byte_clk_hs),
        .reset_n_byte  (reset_n_byte),
        .sp_en_i       (sp_en_i),
        .frame_start_i (frame_start_i),
        .payload_en_i  (payload_en_i),
        .payload_i     (payload_i),
        .group_valid_o (group_valid),
        .group_o       (group)
    );

    pixel_group_fifo u_pixel_group_fifo (
        .byte_clk_hs   (byte_clk_hs),
        .reset_n_byte  (reset_n_byte),
        .group_valid_i (group_valid),
        .group_i       (group),
        .pix           (u_pix_if.source)
    );

    frame_packer u_frame_packer (
        .byte_clk_hs  (byte_clk_hs),
        .reset_n_byte (reset_n_byte),
        .pix          (u_pix_if.sink),
        .wr_en_o      (wr_en),
        .wr_addr_o    (wr_addr),
        .wr_data_o    (wr_data),
        .frame_done_o (frame_done_o)
    );

    frame_ram u_frame_ram (
        .byte_clk_hs  (byte_clk_hs),
        .reset_n_byte (reset_n_byte),
        .wr_en_i      (wr_en),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .rd_en_i      (ram_read_en_i),
        .rd_addr_i    (ram_read_addr_i),
        .rd_data_o    (ram_read_data_o)
    );

endmodule

//--- hdl/frame_ram.sv
/*
 * Simple dual-port frame RAM, one write and one registered read port.
 * Contents are undefined until written.
 */

`timescale 1ns/1ps

module frame_ram (
    input  logic                              byte_clk_hs,
    input  logic                              reset_n_byte,
    input  logic                              wr_en_i,
    input  logic [camera_pkg::RAM_ADDR_W-1:0] wr_addr_i,
    input  logic [31:0]                       wr_data_i,
    input  logic                              rd_en_i,
    input  logic [camera_pkg::RAM_ADDR_W-1:0] rd_addr_i,
    output logic [31:0]                       rd_data_o
);
    import camera_pkg::*;

    logic [31:0] mem [RAM_WORDS];

    always_ff @(posedge byte_clk_hs) begin
        if (wr_en_i)
            mem[wr_addr_i] <= wr_data_i;
    end

    always_ff @(posedge byte_clk_hs or negedge reset_n_byte) begin
        if (!reset_n_byte)
            rd_data_o <= '0;
        else if (rd_en_i)
            rd_data_o <= mem[rd_addr_i];   // holds between reads
    end

endmodule

//--- hdl/frame_packer.sv
/*
 * Crops the pixel stream and packs the upper 8 bits of four pixels per word,
 * pixel 0 in the low byte. Lines past the crop are ignored until frame_start.
 */

`timescale 1ns/1ps

module frame_packer (
    input  logic                              byte_clk_hs,
    input  logic                              reset_n_byte,
    pixel_stream_if.sink                      pix,
    output logic                              wr_en_o,
    output logic [camera_pkg::RAM_ADDR_W-1:0] wr_addr_o,
    output logic [31:0]                       wr_data_o,
    output logic                              frame_done_o
);
    import camera_pkg::*;

    logic [COL_W-1:0]      col;
    logic [ROW_W-1:0]      row;
    logic [COL_W-1:0]      col_pos;    // position of the current pixel
    logic [ROW_W-1:0]      row_pos;
    logic [COL_W-1:0]      col_rel;
    logic [RAM_ADDR_W-1:0] addr;
    logic [RAM_ADDR_W-1:0] addr_cur;
    logic [31:0]           word;
    logic [31:0]           word_next;
    logic                  in_win;
    logic                  wr_now;
    logic                  last_word;

    always_comb begin
        col_pos = pix.line_start ? '0 : col;
        if (pix.frame_start)
            row_pos = '0;
        else if (pix.line_start && row != '1)
            row_pos = row + 1'b1;
        else
            row_pos = row;             // saturates past the crop
    end

    assign col_rel   = col_pos - COL_W'(CROP_X0);
    assign in_win    = pix.valid
                    && col_pos >= CROP_X0 && col_pos < CROP_X0 + CROP_W
                    && row_pos >= CROP_Y0 && row_pos < CROP_Y0 + CROP_H;
    assign wr_now    = in_win && (col_rel[1:0] == 2'd3);
    assign last_word = (col_pos == CROP_X0 + CROP_W - 1) && (row_pos == CROP_Y0 + CROP_H - 1);
    assign addr_cur  = pix.frame_start ? '0 : addr;
    assign word_next = {pix.pixel[PIXEL_W-1 -: 8], word[31:8]};

    always_ff @(posedge byte_clk_hs or negedge reset_n_byte) begin
        if (!reset_n_byte) begin
            col          <= '0;
            row          <= '0;
            addr         <= '0;
            wr_en_o      <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            wr_en_o      <= wr_now;
            frame_done_o <= wr_now && last_word;
            if (pix.valid) begin
                col  <= col_pos + 1'b1;
                row  <= row_pos;
                addr <= wr_now ? addr_cur + 1'b1 : addr_cur;
            end
        end
    end

    always_ff @(posedge byte_clk_hs) begin
        if (in_win)
            word <= word_next;
        if (wr_now) begin
            wr_data_o <= word_next;
            wr_addr_o <= addr_cur;
        end
    end

endmodule

//--- hdl/pixel_group_fifo.sv
/*
 * Group FIFO and 4:1 width converter. Drains one pixel per cycle and never
 * checks for overflow, which relies on the 5 byte to 4 pixel input rate.
 */

`timescale 1ns/1ps

module pixel_group_fifo (
    input  logic                     byte_clk_hs,
    input  logic                     reset_n_byte,
    input  logic                     group_valid_i,
    input  camera_pkg::pixel_group_t group_i,
    pixel_stream_if.source           pix
);
    import camera_pkg::*;

    pixel_group_t          mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic [1:0]            pix_idx;
    logic                  not_empty;
    logic                  pop;
    pixel_group_t          head;

    assign not_empty = (count != '0);
    assign pop       = not_empty && (pix_idx == 2'd3);   // last pixel of the head group
    assign head      = mem[rd_ptr];

    assign pix.valid       = not_empty;
    assign pix.pixel       = head.pix[pix_idx];
    assign pix.line_start  = not_empty && (pix_idx == 2'd0) && head.line_start;
    assign pix.frame_start = not_empty && (pix_idx == 2'd0) && head.frame_start;

    always_ff @(posedge byte_clk_hs) begin
        if (group_valid_i)
            mem[wr_ptr] <= group_i;
    end

    always_ff @(posedge byte_clk_hs or negedge reset_n_byte) begin
        if (!reset_n_byte) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            pix_idx <= '0;
        end else begin
            if (group_valid_i)
                wr_ptr <= wr_ptr + 1'b1;
            if (not_empty)
                pix_idx <= pix_idx + 2'd1;   // wraps to 0 on pop
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({group_valid_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/raw10_unpacker.sv
/*
 * RAW10 byte unpacker. sp_en_i must come before the first payload byte of a
 * packet, never in the same cycle, and a packet must hold whole 5 byte groups.
 */

`timescale 1ns/1ps

module raw10_unpacker (
    input  logic                     byte_clk_hs,
    input  logic                     reset_n_byte,
    input  logic                     sp_en_i,
    input  logic                     frame_start_i,
    input  logic                     payload_en_i,
    input  logic [7:0]               payload_i,
    output logic                     group_valid_o,
    output camera_pkg::pixel_group_t group_o
);

    logic [2:0]      byte_cnt;
    logic [3:0][7:0] msb;           // upper bytes of the current group
    logic            line_pend;
    logic            frame_pend;
    logic            last_byte;

    assign last_byte = payload_en_i && (byte_cnt == 3'd4);

    always_ff @(posedge byte_clk_hs or negedge reset_n_byte) begin
        if (!reset_n_byte) begin
            byte_cnt      <= '0;
            line_pend     <= 1'b0;
            frame_pend    <= 1'b0;
            group_valid_o <= 1'b0;
        end else begin
            group_valid_o <= last_byte;
            if (sp_en_i) begin
                byte_cnt  <= '0;
                line_pend <= 1'b1;
                if (frame_start_i)
                    frame_pend <= 1'b1;
            end else if (payload_en_i) begin
                if (last_byte) begin
                    byte_cnt   <= '0;
                    line_pend  <= 1'b0;    // flags go out with this group
                    frame_pend <= 1'b0;
                end else begin
                    byte_cnt <= byte_cnt + 3'd1;
                end
            end
        end
    end

    // data path qualified by group_valid_o
    always_ff @(posedge byte_clk_hs) begin
        if (payload_en_i && !last_byte)
            msb[byte_cnt[1:0]] <= payload_i;
        if (last_byte) begin
            for (int i = 0; i < 4; i++) begin
                group_o.pix[i] <= {msb[i], payload_i[2*i +: 2]};   // lsb pair i
            end
            group_o.line_start  <= line_pend;
            group_o.frame_start <= frame_pend;
        end
    end

endmodule

//--- hdl/pixel_stream_if.sv
/*
 * Single-pixel stream, one pixel per valid cycle, no back-pressure.
 * line_start and frame_start qualify the pixel they arrive with.
 */

`timescale 1ns/1ps

interface pixel_stream_if;
    import camera_pkg::*;

    logic               valid;
    logic [PIXEL_W-1:0] pixel;
    logic               line_start;
    logic               frame_start;

    modport source (output valid, pixel, line_start, frame_start);
    modport sink   (input  valid, pixel, line_start, frame_start);

endinterface

//--- hdl/camera_pkg.sv
/*
 * Shared geometry and types for the RAW10 crop path. CROP_W must be a
 * multiple of 4 and the crop must fit inside one frame of LINE_PIXELS columns.
 */

package camera_pkg;

    localparam int PIXEL_W     = 10;    // raw RAW10 pixel
    localparam int LINE_PIXELS = 16;    // one 20 byte packet per line

    // crop window in pixels and lines
    localparam int CROP_X0 = 4;
    localparam int CROP_W  = 8;         // multiple of 4
    localparam int CROP_Y0 = 1;
    localparam int CROP_H  = 3;

    localparam int RAM_ADDR_W = 8;
    localparam int RAM_WORDS  = 1 << RAM_ADDR_W;

    localparam int FIFO_DEPTH = 4;      // pixel groups
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // position counter widths in the packer
    localparam int COL_W = $clog2(LINE_PIXELS);
    localparam int ROW_W = $clog2(CROP_Y0 + CROP_H + 1);

    typedef struct packed {
        logic                      frame_start;
        logic                      line_start;
        logic [3:0][PIXEL_W-1:0]   pix;         // pix[0] is the earliest
    } pixel_group_t;

endpackage
